// ==== rst_pkg.sv ====
// ======================================================================
// Shared definitions of the clock and reset controller
// Button monitor state encoding
// Reset sequencer state encoding
// Fixed microsecond to millisecond ratio
// ======================================================================

package rst_pkg;

   // Oscillator domain button monitor states
   typedef enum logic [1:0]
   {
      KEY_RELEASED = 2'd0,       // Button up, debounce done
      KEY_DEBOUNCE = 2'd1,       // Button up, counting release time
      KEY_HELD     = 2'd2,       // Button down or PLL unlocked
      KEY_LONG     = 2'd3        // Press lasted past the long limit
   } key_state_t;

   // System domain reset sequencer states
   typedef enum logic [2:0]
   {
      SEQ_POWER      = 3'd0,     // pwr_rst active, width counting
      SEQ_WAIT_READY = 3'd1,     // sys_rst active until system is ready
      SEQ_DCLO       = 3'd2,     // DCLO width counting
      SEQ_ACLO       = 3'd3,     // ACLO delay counting
      SEQ_RUN        = 3'd4      // All resets released
   } seq_state_t;

   // Microsecond strobes in one millisecond
   localparam int US_PER_MS = 1000;

endpackage

// ==== rst_button_monitor.sv ====
// ======================================================================
// Oscillator domain reset button monitor
// Millisecond prescaler from osc_clk
// PLL lock and button input registers
// Release debouncer and long press detector
// ======================================================================

`timescale 1ns/1ps

module rst_button_monitor #(
   parameter int OSC_PER_MS = 50000,   // osc_clk cycles per millisecond
   parameter int DEBOUNCE   = 10,      // Release debounce time in ms
   parameter int LONGKEY    = 1000     // Long press limit in ms
)
(
   input  logic osc_clk,
   input  logic pwr_event,             // Async power event reset
   input  logic pll_lock,              // PLL lock status, async
   input  logic button_n,              // Reset button, active low
   output logic key_hold,              // Press or debounce in progress
   output logic pwr_req                // Power reset request
);

   localparam int OS_W   = $clog2(OSC_PER_MS + 1);
   localparam int MS_MAX = (LONGKEY > DEBOUNCE) ? LONGKEY : DEBOUNCE;
   localparam int MS_W   = $clog2(MS_MAX + 1);

   logic [OS_W-1:0]      os_cnt;       // Prescaler count
   logic                 ms_tick;      // One cycle per millisecond
   logic                 pll_reg;
   logic                 but_reg;
   logic                 key_down;     // Button pressed or lock lost
   logic [MS_W-1:0]      ms_cnt;       // Shared debounce and long press count
   rst_pkg::key_state_t  key_state;

   // Millisecond prescaler
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         os_cnt  <= '0;
         ms_tick <= 1'b0;
      end
      else if (os_cnt == OS_W'(OSC_PER_MS - 1))
      begin
         os_cnt  <= '0;
         ms_tick <= 1'b1;              // Terminal count
      end
      else
      begin
         os_cnt  <= os_cnt + 1'b1;
         ms_tick <= 1'b0;
      end
   end

   // Input registers, idle values keep pwr_req low after reset
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         pll_reg <= 1'b1;
         but_reg <= 1'b1;
      end
      else
      begin
         pll_reg <= pll_lock;
         but_reg <= button_n;
      end
   end

   assign key_down = ~but_reg | ~pll_reg;

   // Debounce and long press FSM
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         key_state <= rst_pkg::KEY_DEBOUNCE;   // Debounce again after power event
         ms_cnt    <= '0;
      end
      else
      begin
         case (key_state)
            rst_pkg::KEY_RELEASED:
            begin
               if (key_down)
               begin
                  key_state <= rst_pkg::KEY_HELD;
                  ms_cnt    <= '0;
               end
            end
            rst_pkg::KEY_DEBOUNCE:
            begin
               if (key_down)
               begin
                  key_state <= rst_pkg::KEY_HELD;   // Bounce restarts the press
                  ms_cnt    <= '0;
               end
               else if (ms_tick)
               begin
                  if (ms_cnt == MS_W'(DEBOUNCE - 1))
                  begin
                     key_state <= rst_pkg::KEY_RELEASED;
                     ms_cnt    <= '0;
                  end
                  else
                     ms_cnt <= ms_cnt + 1'b1;
               end
            end
            rst_pkg::KEY_HELD:
            begin
               if (!key_down)
               begin
                  key_state <= rst_pkg::KEY_DEBOUNCE;
                  ms_cnt    <= '0;
               end
               else if (ms_tick)
               begin
                  if (ms_cnt == MS_W'(LONGKEY - 1))
                  begin
                     key_state <= rst_pkg::KEY_LONG;   // Long press seen
                     ms_cnt    <= '0;
                  end
                  else
                     ms_cnt <= ms_cnt + 1'b1;
               end
            end
            default:                                 // KEY_LONG
            begin
               if (!key_down)
               begin
                  key_state <= rst_pkg::KEY_DEBOUNCE;
                  ms_cnt    <= '0;
               end
            end
         endcase
      end
   end

   // Power request on lock loss or long press
   always_ff @(posedge osc_clk or posedge pwr_event)
   begin
      if (pwr_event)
         pwr_req <= 1'b0;
      else
         pwr_req <= ~pll_reg | (key_state == rst_pkg::KEY_LONG);
   end

   assign key_hold = (key_state != rst_pkg::KEY_RELEASED);

endmodule

// ==== rst_sequencer.sv ====
// ======================================================================
// System domain reset sequencer
// Two-flop synchronizers for key_hold and pwr_req
// FSM timing pwr_rst, sys_rst, DCLO and ACLO release
// ======================================================================

`timescale 1ns/1ps

module rst_sequencer #(
   parameter int PWR_WIDTH  = 7,       // Minimum pwr_rst width in sys_clk cycles
   parameter int DCLO_WIDTH = 15,      // DCLO width after sys_rst release
   parameter int ACLO_DELAY = 7        // ACLO release delay after DCLO
)
(
   input  logic sys_clk,
   input  logic pwr_event,             // Async power event reset
   input  logic key_hold,              // From osc_clk domain
   input  logic pwr_req,               // From osc_clk domain
   input  logic sys_ready,             // System initialization done
   output logic pwr_rst,
   output logic sys_rst,
   output logic sys_dclo,
   output logic sys_aclo
);

   localparam int MAX_A  = (PWR_WIDTH > DCLO_WIDTH) ? PWR_WIDTH : DCLO_WIDTH;
   localparam int MAX_W  = (MAX_A > ACLO_DELAY) ? MAX_A : ACLO_DELAY;
   localparam int CNT_W  = $clog2(MAX_W + 1);

   logic                 key_meta;
   logic                 key_sync;     // key_hold in sys_clk domain
   logic                 req_meta;
   logic                 req_sync;     // pwr_req in sys_clk domain
   logic [CNT_W-1:0]     int_cnt;      // Shared interval counter
   rst_pkg::seq_state_t  seq_state;

   // Synchronizers, key side resets to held like the monitor
   always_ff @(posedge sys_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         key_meta <= 1'b1;
         key_sync <= 1'b1;
         req_meta <= 1'b0;
         req_sync <= 1'b0;
      end
      else
      begin
         key_meta <= key_hold;
         key_sync <= key_meta;
         req_meta <= pwr_req;
         req_sync <= req_meta;
      end
   end

   // Sequencer FSM with registered outputs
   always_ff @(posedge sys_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         seq_state <= rst_pkg::SEQ_POWER;
         int_cnt   <= '0;
         pwr_rst   <= 1'b1;
         sys_rst   <= 1'b1;
         sys_dclo  <= 1'b1;
         sys_aclo  <= 1'b1;
      end
      else if (req_sync)
      begin
         // Power restart, held here until the request drops
         seq_state <= rst_pkg::SEQ_POWER;
         int_cnt   <= '0;
         pwr_rst   <= 1'b1;
         sys_rst   <= 1'b1;
         sys_dclo  <= 1'b1;
         sys_aclo  <= 1'b1;
      end
      else if (key_sync && (seq_state != rst_pkg::SEQ_POWER))
      begin
         // Warm restart leaves pwr_rst alone
         seq_state <= rst_pkg::SEQ_WAIT_READY;
         int_cnt   <= '0;
         sys_rst   <= 1'b1;
         sys_dclo  <= 1'b1;
         sys_aclo  <= 1'b1;
      end
      else
      begin
         case (seq_state)
            rst_pkg::SEQ_POWER:
            begin
               if (int_cnt == CNT_W'(PWR_WIDTH - 1))
               begin
                  seq_state <= rst_pkg::SEQ_WAIT_READY;
                  int_cnt   <= '0;
                  pwr_rst   <= 1'b0;
               end
               else
                  int_cnt <= int_cnt + 1'b1;
            end
            rst_pkg::SEQ_WAIT_READY:
            begin
               if (sys_ready)          // key_sync low here, pwr_rst already low
               begin
                  seq_state <= rst_pkg::SEQ_DCLO;
                  int_cnt   <= '0;
                  sys_rst   <= 1'b0;
               end
            end
            rst_pkg::SEQ_DCLO:
            begin
               if (int_cnt == CNT_W'(DCLO_WIDTH - 1))
               begin
                  seq_state <= rst_pkg::SEQ_ACLO;
                  int_cnt   <= '0;
                  sys_dclo  <= 1'b0;
               end
               else
                  int_cnt <= int_cnt + 1'b1;
            end
            rst_pkg::SEQ_ACLO:
            begin
               if (int_cnt == CNT_W'(ACLO_DELAY - 1))
               begin
                  seq_state <= rst_pkg::SEQ_RUN;
                  int_cnt   <= '0;
                  sys_aclo  <= 1'b0;
               end
               else
                  int_cnt <= int_cnt + 1'b1;
            end
            rst_pkg::SEQ_RUN:
               int_cnt <= '0;          // Idle until a restart
            default:
            begin
               seq_state <= rst_pkg::SEQ_POWER;   // Illegal encoding recovery
               int_cnt   <= '0;
               pwr_rst   <= 1'b1;
               sys_rst   <= 1'b1;
               sys_dclo  <= 1'b1;
               sys_aclo  <= 1'b1;
            end
         endcase
      end
   end

endmodule

// ==== sys_tick_gen.sv ====
// ======================================================================
// System tick generator
// 1 us and 1 ms clock enable strobes
// Periodic timer interrupt, square wave of SYSTICK us
// ======================================================================

`timescale 1ns/1ps

module sys_tick_gen #(
   parameter int SYS_PER_US = 100,     // sys_clk cycles per microsecond
   parameter int SYSTICK    = 20000    // Timer interrupt period in us
)
(
   input  logic sys_clk,
   input  logic pwr_event,             // Async power event reset
   input  logic sys_rst,               // Sync hold while system is in reset
   output logic sys_us,
   output logic sys_ms,
   output logic sys_irq
);

   localparam int US_W = $clog2(SYS_PER_US + 1);
   localparam int MS_W = $clog2(rst_pkg::US_PER_MS + 1);
   localparam int ST_W = $clog2(SYSTICK + 1);

   logic [US_W-1:0] us_cnt;            // Cycles within one microsecond
   logic [MS_W-1:0] ms_cnt;            // Microseconds within one millisecond
   logic [ST_W-1:0] st_cnt;            // Microseconds within one systick
   logic            us_tick;           // Last cycle of each microsecond

   assign us_tick = (us_cnt == US_W'(SYS_PER_US - 1));

   always_ff @(posedge sys_clk or posedge pwr_event)
   begin
      if (pwr_event)
      begin
         us_cnt  <= '0;
         ms_cnt  <= '0;
         st_cnt  <= '0;
         sys_us  <= 1'b0;
         sys_ms  <= 1'b0;
         sys_irq <= 1'b0;
      end
      else if (sys_rst)
      begin
         us_cnt  <= '0;
         ms_cnt  <= '0;
         st_cnt  <= '0;
         sys_us  <= 1'b0;
         sys_ms  <= 1'b0;
         sys_irq <= 1'b0;
      end
      else
      begin
         // Microsecond divider
         if (us_tick)
            us_cnt <= '0;
         else
            us_cnt <= us_cnt + 1'b1;
         sys_us <= us_tick;

         // Millisecond strobe lines up with the matching sys_us pulse
         sys_ms <= us_tick && (ms_cnt == MS_W'(rst_pkg::US_PER_MS - 1));

         if (us_tick)
         begin
            if (ms_cnt == MS_W'(rst_pkg::US_PER_MS - 1))
               ms_cnt <= '0;               // Wrap every millisecond
            else
               ms_cnt <= ms_cnt + 1'b1;

            // Systick, low first half and high second half
            if (st_cnt == ST_W'(SYSTICK - 1))
            begin
               st_cnt  <= '0;
               sys_irq <= 1'b0;
            end
            else
            begin
               st_cnt <= st_cnt + 1'b1;
               if (st_cnt == ST_W'(SYSTICK / 2 - 1))
                  sys_irq <= 1'b1;         // Half period reached
            end
         end
      end
   end

endmodule

// ==== clk_rst_ctrl.sv ====
// ======================================================================
// Clock and reset controller top level
// Button monitor in osc_clk domain
// Reset sequencer and tick generator in sys_clk domain
// ======================================================================

`timescale 1ns/1ps

module clk_rst_ctrl #(
   parameter int OSC_PER_MS = 50000,   // osc_clk cycles per millisecond
   parameter int DEBOUNCE   = 10,      // Button release debounce in ms
   parameter int LONGKEY    = 1000,    // Long press limit in ms
   parameter int PWR_WIDTH  = 7,       // Minimum pwr_rst width, sys_clk cycles
   parameter int DCLO_WIDTH = 15,      // DCLO width, sys_clk cycles
   parameter int ACLO_DELAY = 7,       // ACLO after DCLO, sys_clk cycles
   parameter int SYS_PER_US = 100,     // sys_clk cycles per microsecond
   parameter int SYSTICK    = 20000    // Timer interrupt period in us
)
(
   input  logic osc_clk,
   input  logic sys_clk,
   input  logic pwr_event,             // External async power event
   input  logic pll_lock,
   input  logic button_n,
   input  logic sys_ready,
   output logic pwr_rst,
   output logic sys_rst,
   output logic sys_dclo,
   output logic sys_aclo,
   output logic sys_us,
   output logic sys_ms,
   output logic sys_irq
);

   logic key_hold;                     // osc_clk domain, crosses to sys_clk
   logic pwr_req;                      // osc_clk domain, crosses to sys_clk

   rst_button_monitor #(
      .OSC_PER_MS (OSC_PER_MS),
      .DEBOUNCE   (DEBOUNCE),
      .LONGKEY    (LONGKEY)
   ) button_monitor_i (
      .osc_clk    (osc_clk),
      .pwr_event  (pwr_event),
      .pll_lock   (pll_lock),
      .button_n   (button_n),
      .key_hold   (key_hold),
      .pwr_req    (pwr_req)
   );

   rst_sequencer #(
      .PWR_WIDTH  (PWR_WIDTH),
      .DCLO_WIDTH (DCLO_WIDTH),
      .ACLO_DELAY (ACLO_DELAY)
   ) sequencer_i (
      .sys_clk    (sys_clk),
      .pwr_event  (pwr_event),
      .key_hold   (key_hold),
      .pwr_req    (pwr_req),
      .sys_ready  (sys_ready),
      .pwr_rst    (pwr_rst),
      .sys_rst    (sys_rst),
      .sys_dclo   (sys_dclo),
      .sys_aclo   (sys_aclo)
   );

   // Ticks held off while the system is in reset
   sys_tick_gen #(
      .SYS_PER_US (SYS_PER_US),
      .SYSTICK    (SYSTICK)
   ) tick_gen_i (
      .sys_clk    (sys_clk),
      .pwr_event  (pwr_event),
      .sys_rst    (sys_rst),
      .sys_us     (sys_us),
      .sys_ms     (sys_ms),
      .sys_irq    (sys_irq)
   );

endmodule

// ==== tb_clk_rst_ctrl.sv ====
// ======================================================================
// Testbench of the clock and reset controller
// Two free running clocks, power event, button and PLL lock stimulus
// Concurrent assertions on reset order, widths and tick timing
// Error count, cycle limit and final verdict
// ======================================================================

`timescale 1ns/1ps

module tb_clk_rst_ctrl;

   localparam int OSC_PER_MS = 8;
   localparam int DEBOUNCE   = 3;
   localparam int LONGKEY    = 20;
   localparam int PWR_WIDTH  = 7;
   localparam int DCLO_WIDTH = 15;
   localparam int ACLO_DELAY = 7;
   localparam int SYS_PER_US = 4;
   localparam int SYSTICK    = 10;
   localparam int MS_CYCLES  = rst_pkg::US_PER_MS * SYS_PER_US;   // sys_clk cycles per ms
   localparam int MAX_CYCLES = 2 * MS_CYCLES + 4000;   // Two ms of ticks plus button tests
   localparam int UNLOCK_LAT = 8;                      // Lock loss to pwr_rst bound

   logic   osc_clk, sys_clk, pwr_event, pll_lock, button_n, sys_ready;
   logic   pwr_rst, sys_rst, sys_dclo, sys_aclo, sys_us, sys_ms, sys_irq;
   logic   pwr_q, srst_q, ready_q;     // Values seen one sys_clk edge earlier
   logic   in_powerup, in_warm;        // Test phase flags
   int     ev_cnt;                     // Edges since pwr_event release
   int     low_cnt;                    // Edges since sys_rst fall
   int     free_cnt;                   // Edges with button up and lock present
   int     press_cnt;                  // Edges with button down
   int     unlock_cnt;                 // Edges with lock lost
   int     ms_seen, cycles, errors, delay;
   integer seed;

   clk_rst_ctrl #(
      .OSC_PER_MS (OSC_PER_MS), .DEBOUNCE (DEBOUNCE), .LONGKEY (LONGKEY),
      .PWR_WIDTH (PWR_WIDTH), .DCLO_WIDTH (DCLO_WIDTH), .ACLO_DELAY (ACLO_DELAY),
      .SYS_PER_US (SYS_PER_US), .SYSTICK (SYSTICK)
   ) clk_rst_ctrl_i (
      .osc_clk (osc_clk), .sys_clk (sys_clk), .pwr_event (pwr_event),
      .pll_lock (pll_lock), .button_n (button_n), .sys_ready (sys_ready),
      .pwr_rst (pwr_rst), .sys_rst (sys_rst), .sys_dclo (sys_dclo),
      .sys_aclo (sys_aclo), .sys_us (sys_us), .sys_ms (sys_ms), .sys_irq (sys_irq)
   );

   initial
   begin
      osc_clk = 1'b0;
      sys_clk = 1'b0;
   end

   always #50 osc_clk = ~osc_clk;

   always                              // Same period, 30 ns behind osc_clk
   begin
      #30;
      forever #50 sys_clk = ~sys_clk;
   end

   task automatic report_mismatch(input string name, input int exp, input int act);
      errors = errors + 1;
      $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
   endtask

   task automatic report_range(input string name, input int lo, input int hi, input int act);
      errors = errors + 1;
      $display("CHECK FAILED %s expected %0d..%0d actual %0d", name, lo, hi, act);
   endtask

   task automatic osc_cycles(input int n);   // Lands 10 ns after a rising osc_clk edge
      repeat (n) @(posedge osc_clk);
      #10;
   endtask

   task automatic wait_release;              // Whole sequence done once ACLO is low
      while (sys_aclo)
         osc_cycles(1);
   endtask

   // History and interval counters, sampled with the assertions
   always @(posedge sys_clk)
   begin
      cycles <= cycles + 1;
      ready_q <= sys_ready;
      if (pwr_event)
      begin
         pwr_q   <= 1'b1;              // Reset values of the outputs
         srst_q  <= 1'b1;
         ev_cnt  <= 0;
         low_cnt <= 0;
      end
      else
      begin
         pwr_q   <= pwr_rst;
         srst_q  <= sys_rst;
         ev_cnt  <= ev_cnt + 1;
         low_cnt <= sys_rst ? 0 : low_cnt + 1;
      end
      free_cnt   <= (!button_n || !pll_lock) ? 0 : free_cnt + 1;
      press_cnt  <= button_n ? 0 : press_cnt + 1;
      unlock_cnt <= pll_lock ? 0 : unlock_cnt + 1;
      if (sys_ms)
         ms_seen <= ms_seen + 1;
   end

   always @(posedge sys_clk)
   begin
      if (cycles == MAX_CYCLES)
      begin
         $display("Timeout, the run did not finish within %0d sys_clk cycles", MAX_CYCLES);
         $display("TB FAILED");
         $finish;
      end
   end

   pwr_width_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      in_powerup |-> (pwr_rst == (ev_cnt < PWR_WIDTH)))
      else report_mismatch("pwr_width", int'(ev_cnt < PWR_WIDTH), int'(pwr_rst));
   pwr_order_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      pwr_rst |-> sys_rst)
      else report_mismatch("pwr_before_sys", 1, int'(sys_rst));
   ready_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      (srst_q && !sys_rst) |-> (ready_q && !pwr_q))
      else report_mismatch("sys_rst_needs_ready", 1, int'(ready_q && !pwr_q));
   debounce_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      (srst_q && !sys_rst) |-> (free_cnt >= (DEBOUNCE - 1) * OSC_PER_MS))
      else report_mismatch("debounce_min", (DEBOUNCE - 1) * OSC_PER_MS, free_cnt);
   dclo_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      sys_dclo == (sys_rst || low_cnt < DCLO_WIDTH))
      else report_mismatch("dclo_width", int'(sys_rst || low_cnt < DCLO_WIDTH), int'(sys_dclo));
   aclo_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      sys_aclo == (sys_rst || low_cnt < DCLO_WIDTH + ACLO_DELAY))
      else report_mismatch("aclo_delay", int'(sys_rst || low_cnt < DCLO_WIDTH + ACLO_DELAY),
                           int'(sys_aclo));
   us_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      !sys_rst |-> (sys_us == (low_cnt > 0 && low_cnt % SYS_PER_US == 0)))
      else report_mismatch("us_strobe", int'(low_cnt > 0 && low_cnt % SYS_PER_US == 0),
                           int'(sys_us));
   ms_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      !sys_rst |-> (sys_ms == (low_cnt > 0 && low_cnt % MS_CYCLES == 0)))
      else report_mismatch("ms_strobe", int'(low_cnt > 0 && low_cnt % MS_CYCLES == 0),
                           int'(sys_ms));
   irq_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      !sys_rst |-> (sys_irq == ((low_cnt / SYS_PER_US) % SYSTICK >= SYSTICK / 2)))
      else report_mismatch("irq_phase", int'((low_cnt / SYS_PER_US) % SYSTICK >= SYSTICK / 2),
                           int'(sys_irq));
   // Tick block follows sys_rst one edge late
   tick_rst_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      (sys_rst && srst_q) |-> !(sys_us || sys_ms || sys_irq))
      else report_mismatch("ticks_in_reset", 0, int'(sys_us || sys_ms || sys_irq));
   warm_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      in_warm |-> !pwr_rst)
      else report_mismatch("warm_keeps_pwr", 0, int'(pwr_rst));
   unlock_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      (unlock_cnt >= UNLOCK_LAT) |-> pwr_rst)
      else report_mismatch("unlock_pwr_rst", 1, int'(pwr_rst));
   cause_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      (!pwr_q && pwr_rst) |-> (unlock_cnt > 0 || press_cnt >= (LONGKEY - 1) * OSC_PER_MS))
      else report_mismatch("long_press_min", (LONGKEY - 1) * OSC_PER_MS, press_cnt);
   // Request drop crosses two or three flops, then PWR_WIDTH edges
   restart_chk: assert property (@(posedge sys_clk) disable iff (pwr_event)
      (pwr_q && !pwr_rst && !in_powerup) |->
      (free_cnt >= PWR_WIDTH + 3 && free_cnt <= PWR_WIDTH + 7))
      else report_range("pwr_restart_width", PWR_WIDTH + 3, PWR_WIDTH + 7, free_cnt);

   initial
   begin
      seed       = 32'h403e_0390;
      errors     = 0;
      cycles     = 0;
      ms_seen    = 0;
      free_cnt   = 0;
      press_cnt  = 0;
      unlock_cnt = 0;
      in_powerup = 1'b1;
      in_warm    = 1'b0;
      pwr_event  = 1'b1;
      pll_lock   = 1'b1;
      button_n   = 1'b1;
      sys_ready  = 1'b0;
      osc_cycles(2);
      pwr_event = 1'b0;

      // Power-up with a late sys_ready, then two ms of ticks
      delay = (DEBOUNCE + 1) * OSC_PER_MS + 8 + ($random(seed) & 31);   // After debounce
      osc_cycles(delay);
      sys_ready = 1'b1;
      wait_release();
      in_powerup = 1'b0;
      osc_cycles(2 * MS_CYCLES + 100);
      assert (ms_seen == 2) else report_mismatch("ms_count", 2, ms_seen);

      // Short press, warm restart only
      in_warm  = 1'b1;
      button_n = 1'b0;
      osc_cycles(5 * OSC_PER_MS + ($random(seed) & 7));
      assert (sys_rst) else report_mismatch("short_press_sys_rst", 1, int'(sys_rst));
      button_n = 1'b1;
      wait_release();
      in_warm = 1'b0;

      // Long press, power restart
      button_n = 1'b0;
      osc_cycles(25 * OSC_PER_MS + ($random(seed) & 7));
      assert (pwr_rst) else report_mismatch("long_press_pwr_rst", 1, int'(pwr_rst));
      button_n = 1'b1;
      wait_release();

      // PLL lock loss
      pll_lock = 1'b0;
      osc_cycles(30 + ($random(seed) & 7));
      assert (pwr_rst) else report_mismatch("unlock_pwr_rst_end", 1, int'(pwr_rst));
      pll_lock = 1'b1;
      wait_release();
      osc_cycles(10);

      $display("Run done, %0d errors in %0d sys_clk cycles", errors, cycles);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

// ==== sim.f ====
rst_pkg.sv
rst_button_monitor.sv
rst_sequencer.sv
sys_tick_gen.sv
clk_rst_ctrl.sv
tb_clk_rst_ctrl.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_clk_rst_ctrl \
   --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/tb_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "^TB PASSED$" <<< "$output"; then
   exit 0
fi
echo "Pass message not found"
exit 1
